//--- src.f
+incdir+tb
source/hilbertPkg.sv
source/coeffLoader.sv
source/tapFir.sv
source/delayAlign.sv
source/outputCredit.sv
source/hilbertControl.sv
source/hilbertTransform.sv
tb/hilbertTb.sv

//--- Bender.yml
package:
  name: hilbert_transform

sources:
  - source/hilbertPkg.sv
  - source/coeffLoader.sv
  - source/tapFir.sv
  - source/delayAlign.sv
  - source/outputCredit.sv
  - source/hilbertControl.sv
  - source/hilbertTransform.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/hilbertTb.sv

//--- tb/hilbertModel.svh
`ifndef HILBERT_MODEL_SVH
`define HILBERT_MODEL_SVH

// Reference model of the analytic pair for the n-th accepted sample.
// It reads sampleHistory, which the testbench fills in the order the DUT accepts samples.

// Samples before the first accepted one count as zero.
function automatic logic signed [hilbertPkg::dataWidth-1:0] historyAt(input int index);
	logic signed [hilbertPkg::dataWidth-1:0] value;
	if (index < 0) begin
		value = '0;
	end else begin
		value = sampleHistory[index];
	end
	return value;
endfunction

// The real part is the input from groupDelay samples back, raised to the Q1.17 tap scale.
// The imaginary part is the direct convolution with the Hilbert taps.
// Both wrap at the output width, like a plain two's complement sum.
function automatic void referenceOutput(
	input int n,
	output logic signed [hilbertPkg::productWidth-1:0] re,
	output logic signed [hilbertPkg::productWidth-1:0] im
);
	longint acc;
	longint delayed;
	acc = 0;
	for (int k = 0; k < hilbertPkg::tapCount; k++) begin
		// Tap k weighs the sample that arrived k samples before sample n.
		acc += longint'(hilbertPkg::coeffTable[k]) * longint'(historyAt(n - k));
	end
	// A shift by dataWidth - 1 is the same as multiplying by 2^17.
	delayed = longint'(historyAt(n - hilbertPkg::groupDelay)) << (hilbertPkg::dataWidth - 1);
	re = delayed[hilbertPkg::productWidth-1:0];
	im = acc[hilbertPkg::productWidth-1:0];
endfunction

// Random 18-bit sample over the full signed range.
function automatic logic signed [hilbertPkg::dataWidth-1:0] randomSample();
	logic [31:0] raw;
	raw = $urandom;
	return raw[hilbertPkg::dataWidth-1:0];
endfunction

`endif

//--- tb/hilbertTb.sv
module hilbertTb;

	// Longest wait for any single event, in clock cycles.
	localparam int waitLimit = 4000;
	// Room for every sample the run sends.
	localparam int historyDepth = 512;

	logic clock;
	logic reset;
	logic start;
	logic stop;
	logic signed [hilbertPkg::dataWidth-1:0] sampleIn = '0;
	logic sampleValid = 1'b0;
	logic inCreditReturn;
	logic signed [hilbertPkg::productWidth-1:0] outRe;
	logic signed [hilbertPkg::productWidth-1:0] outIm;
	logic outValid;
	logic outCreditReturn = 1'b0;
	logic running;
	logic busy;

	// Every sample the DUT accepted, in order. The reference model reads this.
	logic signed [hilbertPkg::dataWidth-1:0] sampleHistory [historyDepth];
	int sentCount = 0;
	int outCount = 0;

	// Samples waiting for the driver, and the input credits the driver holds.
	logic signed [hilbertPkg::dataWidth-1:0] pendingSamples [$];
	int heldCredits = hilbertPkg::inCredits;
	int queuedTotal = 0;

	// Consumer state. Outputs received but not yet given back as credits.
	int unreturned = 0;
	int returnGap = 0;
	int maxGap = 0;
	logic holdCredits = 1'b0;

	`include "hilbertModel.svh"

	hilbertTransform dut_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.stop(stop),
		.sampleIn(sampleIn),
		.sampleValid(sampleValid),
		.inCreditReturn(inCreditReturn),
		.outRe(outRe),
		.outIm(outIm),
		.outValid(outValid),
		.outCreditReturn(outCreditReturn),
		.running(running),
		.busy(busy)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	task automatic stopOnFailure();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic checkValue(
		input string name,
		input logic signed [hilbertPkg::productWidth-1:0] actual,
		input logic signed [hilbertPkg::productWidth-1:0] expected
	);
		if (actual !== expected) begin
			$display("CHECK FAILED at time %0t: %s is %0d, expected %0d",
				$time, name, actual, expected);
			stopOnFailure();
		end
	endtask

	// Pulses start and counts the cycles until the load finishes.
	task automatic startAndCheckLoad();
		int cycles;
		@(negedge clock);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		checkValue("busy", busy, 1'b1);
		cycles = 0;
		while (!running) begin
			@(negedge clock);
			cycles++;
			if (cycles > waitLimit) begin
				$display("Timeout: running never rose after a start pulse.");
				stopOnFailure();
			end
		end
		// One cycle to begin the load, then one coefficient per cycle.
		checkValue("cycles from start to running", cycles, hilbertPkg::tapCount + 1);
	endtask

	task automatic queueRandom(input int count);
		@(posedge clock);
		for (int i = 0; i < count; i++) begin
			pendingSamples.push_back(randomSample());
		end
		queuedTotal += count;
	endtask

	task automatic waitForDriverIdle();
		int cycles;
		cycles = 0;
		while (pendingSamples.size() != 0) begin
			@(posedge clock);
			cycles++;
			if (cycles > waitLimit) begin
				$display("Timeout: the driver never got credits for all queued samples.");
				stopOnFailure();
			end
		end
	endtask

	task automatic waitForOutputs(input int target);
		int cycles;
		cycles = 0;
		while (outCount < target) begin
			@(posedge clock);
			cycles++;
			if (cycles > waitLimit) begin
				$display("Timeout: only %0d of %0d outputs arrived.", outCount, target);
				stopOnFailure();
			end
		end
	endtask

	task automatic waitForUnreturned(input int target);
		int cycles;
		cycles = 0;
		while (unreturned != target) begin
			@(posedge clock);
			cycles++;
			if (cycles > waitLimit) begin
				$display("Timeout: the DUT never used up its output credits.");
				stopOnFailure();
			end
		end
	endtask

	// Stops intake right after the last send, so buffered samples must still drain.
	task automatic stopAndDrain();
		int cycles;
		@(negedge clock);
		stop = 1'b1;
		@(negedge clock);
		stop = 1'b0;
		checkValue("running", running, 1'b0);
		cycles = 0;
		while (busy) begin
			@(negedge clock);
			cycles++;
			if (cycles > waitLimit) begin
				$display("Timeout: busy never fell after a stop pulse.");
				stopOnFailure();
			end
		end
		@(posedge clock);
		checkValue("output count", outCount, sentCount);
		// Nothing may come out once the block is idle.
		repeat (20) begin
			@(negedge clock);
			checkValue("outValid", outValid, 1'b0);
		end
	endtask

	// Upstream side. Credits come back one per inCreditReturn pulse.
	always @(negedge clock) begin : driveSamples
		if (reset) begin
			heldCredits = hilbertPkg::inCredits;
			sampleValid <= 1'b0;
		end else begin
			if (inCreditReturn) begin
				heldCredits++;
			end
			if (heldCredits > hilbertPkg::inCredits) begin
				$display("More input credits came back than the driver had spent.");
				stopOnFailure();
			end
			// Random idle cycles keep the buffer from always being full.
			if (running && heldCredits > 0 && pendingSamples.size() > 0 &&
					($urandom % 4) != 0) begin
				sampleIn <= pendingSamples.pop_front();
				sampleValid <= 1'b1;
				heldCredits--;
			end else begin
				sampleValid <= 1'b0;
			end
		end
	end

	// Records each sample at the edge where the DUT takes it.
	always @(posedge clock) begin : recordSamples
		if (!reset && sampleValid) begin
			if (sentCount >= historyDepth) begin
				$display("The run sent more samples than the history can hold.");
				stopOnFailure();
			end
			sampleHistory[sentCount] = sampleIn;
			sentCount++;
		end
	end

	// Downstream side. Each output is answered by one credit after a random gap.
	always @(negedge clock) begin : consumeOutputs
		if (reset) begin
			unreturned = 0;
			returnGap = 0;
			outCreditReturn <= 1'b0;
		end else begin
			if (outValid) begin
				unreturned++;
				if (unreturned > hilbertPkg::outCredits) begin
					$display("The DUT sent an output without holding an output credit.");
					stopOnFailure();
				end
			end
			if (!holdCredits && unreturned > 0 && returnGap == 0) begin
				outCreditReturn <= 1'b1;
				unreturned--;
				returnGap = $urandom % (maxGap + 1);
			end else begin
				outCreditReturn <= 1'b0;
				if (returnGap > 0) begin
					returnGap--;
				end
			end
		end
	end

	// Compares every output with the reference model, in order.
	always @(negedge clock) begin : compareOutputs
		logic signed [hilbertPkg::productWidth-1:0] expectedRe;
		logic signed [hilbertPkg::productWidth-1:0] expectedIm;
		logic signed [hilbertPkg::productWidth-1:0] impulseRe;
		logic signed [hilbertPkg::productWidth-1:0] impulseIm;
		if (!reset && outValid) begin
			if (outCount >= sentCount) begin
				$display("An output appeared with no input sample behind it.");
				stopOnFailure();
			end
			referenceOutput(outCount, expectedRe, expectedIm);
			checkValue("outRe", outRe, expectedRe);
			checkValue("outIm", outIm, expectedIm);
			// The run opens with a unit impulse, so the first outputs are the taps themselves.
			if (outCount < hilbertPkg::tapCount) begin
				impulseIm = hilbertPkg::coeffTable[outCount];
				impulseRe = '0;
				if (outCount == hilbertPkg::groupDelay) begin
					impulseRe[hilbertPkg::dataWidth-1] = 1'b1;
				end
				checkValue("outIm impulse", outIm, impulseIm);
				checkValue("outRe impulse", outRe, impulseRe);
			end
			outCount++;
		end
	end

	initial begin
		void'($urandom(32'h2f8e));
		reset = 1'b1;
		start = 1'b0;
		stop = 1'b0;
		repeat (16) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		checkValue("running", running, 1'b0);
		checkValue("busy", busy, 1'b0);
		checkValue("outValid", outValid, 1'b0);
		checkValue("inCreditReturn", inCreditReturn, 1'b0);

		startAndCheckLoad();

		// Unit impulse followed by zeros walks the whole table through the output.
		@(posedge clock);
		maxGap = 0;
		pendingSamples.push_back(1);
		for (int i = 1; i < hilbertPkg::tapCount; i++) begin
			pendingSamples.push_back('0);
		end
		queuedTotal += hilbertPkg::tapCount;
		waitForDriverIdle();
		waitForOutputs(queuedTotal);

		// Random stream with prompt credit returns.
		maxGap = 1;
		queueRandom(200);
		waitForDriverIdle();
		waitForOutputs(queuedTotal);

		// Withhold output credits until the whole pipeline stalls.
		holdCredits = 1'b1;
		queueRandom(40);
		waitForUnreturned(hilbertPkg::outCredits);
		repeat (10) @(negedge clock);
		repeat (20) begin
			@(negedge clock);
			checkValue("inCreditReturn", inCreditReturn, 1'b0);
			checkValue("outValid", outValid, 1'b0);
		end
		@(posedge clock);
		holdCredits = 1'b0;
		maxGap = 3;
		waitForDriverIdle();
		waitForOutputs(queuedTotal);

		stopAndDrain();

		// A second start reloads the taps and the history carries on.
		startAndCheckLoad();
		maxGap = 2;
		queueRandom(60);
		waitForDriverIdle();
		stopAndDrain();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- source/hilbertTransform.sv
module hilbertTransform (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic stop,
	input  logic signed [hilbertPkg::dataWidth-1:0] sampleIn,
	input  logic sampleValid,
	output logic inCreditReturn,
	output logic signed [hilbertPkg::productWidth-1:0] outRe,
	output logic signed [hilbertPkg::productWidth-1:0] outIm,
	output logic outValid,
	input  logic outCreditReturn,
	output logic running,
	output logic busy
);

	// Load handshake between the control and the loader.
	logic loadStart;
	logic coeffDone;
	logic coeffShift;
	logic signed [hilbertPkg::dataWidth-1:0] coeffWord;

	// Samples leaving the input buffer.
	logic push;
	logic signed [hilbertPkg::dataWidth-1:0] pushSample;

	// Pipeline movement and drain status.
	logic advance;
	logic pipeEmpty;

	// Results at the end of the two parallel paths.
	logic signed [hilbertPkg::productWidth-1:0] firSum;
	logic firValid;
	logic signed [hilbertPkg::productWidth-1:0] alignedRe;

	hilbertControl control_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.stop(stop),
		.sampleIn(sampleIn),
		.sampleValid(sampleValid),
		.coeffDone(coeffDone),
		.advance(advance),
		.pipeEmpty(pipeEmpty),
		.loadStart(loadStart),
		.push(push),
		.pushSample(pushSample),
		.inCreditReturn(inCreditReturn),
		.running(running),
		.busy(busy)
	);

	coeffLoader loader_i (
		.clock(clock),
		.reset(reset),
		.loadStart(loadStart),
		.coeffOut(coeffWord),
		.coeffShift(coeffShift),
		.coeffDone(coeffDone)
	);

	tapFir fir_i (
		.clock(clock),
		.reset(reset),
		.coeffIn(coeffWord),
		.coeffShift(coeffShift),
		.push(push),
		.pushSample(pushSample),
		.advance(advance),
		.firSum(firSum),
		.firValid(firValid)
	);

	delayAlign align_i (
		.clock(clock),
		.reset(reset),
		.push(push),
		.pushSample(pushSample),
		.advance(advance),
		.alignedRe(alignedRe)
	);

	outputCredit credit_i (
		.clock(clock),
		.reset(reset),
		.firSum(firSum),
		.firValid(firValid),
		.alignedRe(alignedRe),
		.outCreditReturn(outCreditReturn),
		.advance(advance),
		.pipeEmpty(pipeEmpty),
		.outRe(outRe),
		.outIm(outIm),
		.outValid(outValid)
	);

endmodule

//--- source/hilbertControl.sv
module hilbertControl (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic stop,
	input  logic signed [hilbertPkg::dataWidth-1:0] sampleIn,
	input  logic sampleValid,
	input  logic coeffDone,
	input  logic advance,
	input  logic pipeEmpty,
	output logic loadStart,
	output logic push,
	output logic signed [hilbertPkg::dataWidth-1:0] pushSample,
	output logic inCreditReturn,
	output logic running,
	output logic busy
);

	logic [hilbertPkg::stateWidth-1:0] state;

	// Input buffer, one entry per upstream credit.
	logic signed [hilbertPkg::dataWidth-1:0] bufData [hilbertPkg::inCredits];
	logic [hilbertPkg::bufferPtrWidth-1:0] readPtr;
	logic [hilbertPkg::bufferPtrWidth-1:0] writePtr;
	logic [hilbertPkg::bufferCountWidth-1:0] fillCount;
	logic writeEntry;

	// A sample pushed last cycle sits in FIR stage one, which pipeEmpty cannot see.
	logic pushedLast;

	always_comb begin
		running = state == hilbertPkg::stateStreaming;
		busy = state != hilbertPkg::stateIdle;
		// A start outside idle is ignored.
		loadStart = (state == hilbertPkg::stateIdle) && start;
		// Upstream only sends while running, so samples are taken only then.
		writeEntry = sampleValid && running;
		// The oldest entry goes out whenever the pipeline can move.
		push = advance && (fillCount != '0);
		pushSample = bufData[readPtr];
	end

	// Phase sequencing.
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= hilbertPkg::stateIdle;
		end else begin
			case (state)
				hilbertPkg::stateIdle: begin
					if (start) begin
						state <= hilbertPkg::stateLoading;
					end
				end
				hilbertPkg::stateLoading: begin
					if (coeffDone) begin
						state <= hilbertPkg::stateStreaming;
					end
				end
				hilbertPkg::stateStreaming: begin
					// A stop in any other phase is ignored.
					if (stop) begin
						state <= hilbertPkg::stateDraining;
					end
				end
				hilbertPkg::stateDraining: begin
					// Done once nothing is buffered and no stage holds a sample.
					if ((fillCount == '0) && pipeEmpty && !pushedLast) begin
						state <= hilbertPkg::stateIdle;
					end
				end
				default: state <= hilbertPkg::stateIdle;
			endcase
		end
	end

	// Buffer storage.
	always_ff @(posedge clock) begin
		if (writeEntry) begin
			bufData[writePtr] <= sampleIn;
		end
	end

	// Pointers wrap naturally since the depth is a power of two.
	always_ff @(posedge clock) begin
		if (reset) begin
			readPtr <= '0;
			writePtr <= '0;
			fillCount <= '0;
			pushedLast <= 1'b0;
			inCreditReturn <= 1'b0;
		end else begin
			if (writeEntry) begin
				writePtr <= writePtr + 1'b1;
			end
			if (push) begin
				readPtr <= readPtr + 1'b1;
			end
			case ({writeEntry, push})
				2'b10: fillCount <= fillCount + 1'b1;
				2'b01: fillCount <= fillCount - 1'b1;
				default: fillCount <= fillCount;
			endcase
			pushedLast <= push;
			// Every sample moved into the pipeline frees one upstream credit.
			inCreditReturn <= push;
		end
	end

endmodule

//--- source/outputCredit.sv
module outputCredit (
	input  logic clock,
	input  logic reset,
	input  logic signed [hilbertPkg::productWidth-1:0] firSum,
	input  logic firValid,
	input  logic signed [hilbertPkg::productWidth-1:0] alignedRe,
	input  logic outCreditReturn,
	output logic advance,
	output logic pipeEmpty,
	output logic signed [hilbertPkg::productWidth-1:0] outRe,
	output logic signed [hilbertPkg::productWidth-1:0] outIm,
	output logic outValid
);

	// Free downstream slots.
	logic [hilbertPkg::creditWidth-1:0] creditCount;
	logic hasCredit;
	logic send;

	always_comb begin
		hasCredit = creditCount != '0;
		// A result leaves only when downstream has room for it.
		send = firValid && hasCredit;
		// The pipeline may move if the last stage can drain or has nothing to drain.
		advance = hasCredit || !firValid;
		// Stage one is covered by the control, which remembers its own last push.
		pipeEmpty = !firValid;
	end

	// A return and a send in one cycle cancel out.
	always_ff @(posedge clock) begin
		if (reset) begin
			creditCount <= hilbertPkg::creditWidth'(hilbertPkg::outCredits);
			outValid <= 1'b0;
		end else begin
			outValid <= send;
			case ({outCreditReturn, send})
				2'b10: creditCount <= creditCount + 1'b1;
				2'b01: creditCount <= creditCount - 1'b1;
				default: creditCount <= creditCount;
			endcase
		end
	end

	// The output words are only meaningful while outValid is high.
	always_ff @(posedge clock) begin
		if (send) begin
			outRe <= alignedRe;
			outIm <= firSum;
		end
	end

endmodule

//--- source/delayAlign.sv
module delayAlign (
	input  logic clock,
	input  logic reset,
	input  logic push,
	input  logic signed [hilbertPkg::dataWidth-1:0] pushSample,
	input  logic advance,
	output logic signed [hilbertPkg::productWidth-1:0] alignedRe
);

	// Samples from earlier pushes. The last entry is groupDelay pushes old.
	logic signed [hilbertPkg::dataWidth-1:0] realLine [hilbertPkg::groupDelay];

	// Registers that mirror the FIR stages one for one.
	logic signed [hilbertPkg::productWidth-1:0] realPipe [hilbertPkg::firStages];

	logic signed [hilbertPkg::productWidth-1:0] scaledRe;

	// The line shifts on push, exactly like the FIR sample line.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int k = 0; k < hilbertPkg::groupDelay; k++) begin
				realLine[k] <= '0;
			end
		end else if (push) begin
			realLine[0] <= pushSample;
			for (int k = 1; k < hilbertPkg::groupDelay; k++) begin
				realLine[k] <= realLine[k-1];
			end
		end
	end

	// Shift left by 17 and sign extend, so the real part has the Q1.17 scale of the taps.
	assign scaledRe = {
		{(hilbertPkg::productWidth - 2 * hilbertPkg::dataWidth + 1)
			{realLine[hilbertPkg::groupDelay-1][hilbertPkg::dataWidth-1]}},
		realLine[hilbertPkg::groupDelay-1],
		{(hilbertPkg::dataWidth - 1){1'b0}}
	};

	// Same advance gating as the FIR, so the two paths stay lined up under stalls.
	always_ff @(posedge clock) begin
		if (advance) begin
			realPipe[0] <= scaledRe;
			for (int k = 1; k < hilbertPkg::firStages; k++) begin
				realPipe[k] <= realPipe[k-1];
			end
		end
	end

	assign alignedRe = realPipe[hilbertPkg::firStages-1];

endmodule

//--- source/tapFir.sv
module tapFir (
	input  logic clock,
	input  logic reset,
	input  logic signed [hilbertPkg::dataWidth-1:0] coeffIn,
	input  logic coeffShift,
	input  logic push,
	input  logic signed [hilbertPkg::dataWidth-1:0] pushSample,
	input  logic advance,
	output logic signed [hilbertPkg::productWidth-1:0] firSum,
	output logic firValid
);

	// Coefficient chain, loaded serially by the coefficient loader.
	logic signed [hilbertPkg::dataWidth-1:0] coeffReg [hilbertPkg::tapCount];

	// Past samples. Entry zero holds the sample pushed most recently.
	logic signed [hilbertPkg::dataWidth-1:0] sampleLine [hilbertPkg::tapCount-1];

	// The sample seen by each tap, with the incoming sample at tap zero.
	logic signed [hilbertPkg::dataWidth-1:0] tapSample [hilbertPkg::tapCount];

	// Stage one results, one per tap.
	logic signed [hilbertPkg::productWidth-1:0] tapProduct [hilbertPkg::tapCount];

	logic signed [hilbertPkg::productWidth-1:0] productSum;
	logic stageOneValid;

	// Each new coefficient enters at tap zero and pushes the others up one place.
	always_ff @(posedge clock) begin
		if (coeffShift) begin
			coeffReg[0] <= coeffIn;
			for (int k = 1; k < hilbertPkg::tapCount; k++) begin
				coeffReg[k] <= coeffReg[k-1];
			end
		end
	end

	// The sample history moves only when a new sample enters the pipeline.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int k = 0; k < hilbertPkg::tapCount - 1; k++) begin
				sampleLine[k] <= '0;
			end
		end else if (push) begin
			sampleLine[0] <= pushSample;
			for (int k = 1; k < hilbertPkg::tapCount - 1; k++) begin
				sampleLine[k] <= sampleLine[k-1];
			end
		end
	end

	// Stage one multiplies the line as it looks after this push.
	always_comb begin
		tapSample[0] = pushSample;
		for (int k = 1; k < hilbertPkg::tapCount; k++) begin
			tapSample[k] = sampleLine[k-1];
		end
	end

	// Only taps with a nonzero table entry get a multiplier and a register.
	for (genvar k = 0; k < hilbertPkg::tapCount; k++) begin : tapGen
		if (hilbertPkg::coeffTable[k] != 0) begin : multiply
			logic signed [hilbertPkg::productWidth-1:0] product;

			always_ff @(posedge clock) begin
				if (advance) begin
					product <= coeffReg[k] * tapSample[k];
				end
			end

			assign tapProduct[k] = product;
		end else begin : zeroTap
			// Even offsets from the center add nothing.
			assign tapProduct[k] = '0;
		end
	end

	// Adder tree feeding stage two. Results wrap at the full product width.
	always_comb begin
		productSum = '0;
		for (int k = 0; k < hilbertPkg::tapCount; k++) begin
			productSum = productSum + tapProduct[k];
		end
	end

	// Stage two holds the sum.
	always_ff @(posedge clock) begin
		if (advance) begin
			firSum <= productSum;
		end
	end

	// Valid bits travel with the data, so both stages can hold a sample at once.
	always_ff @(posedge clock) begin
		if (reset) begin
			stageOneValid <= 1'b0;
			firValid <= 1'b0;
		end else if (advance) begin
			stageOneValid <= push;
			firValid <= stageOneValid;
		end
	end

endmodule

//--- source/coeffLoader.sv
module coeffLoader (
	input  logic clock,
	input  logic reset,
	input  logic loadStart,
	output logic signed [hilbertPkg::dataWidth-1:0] coeffOut,
	output logic coeffShift,
	output logic coeffDone
);

	// Index of the table entry presented in the current cycle.
	logic [hilbertPkg::coeffIndexWidth-1:0] tapIndex;

	// High while entries are being presented to the FIR.
	logic loading;

	// The table is walked from the last entry to the first.
	// The FIR shifts toward higher indices, so the first entry sent ends up at the top.
	always_ff @(posedge clock) begin
		if (reset) begin
			loading <= 1'b0;
			coeffDone <= 1'b0;
			tapIndex <= '0;
		end else begin
			coeffDone <= 1'b0;
			if (loading) begin
				if (tapIndex == '0) begin
					// Entry zero is on the bus now, so the load ends at this edge.
					loading <= 1'b0;
					coeffDone <= 1'b1;
				end else begin
					tapIndex <= tapIndex - 1'b1;
				end
			end else if (loadStart) begin
				// One cycle to begin, then one entry per cycle.
				loading <= 1'b1;
				tapIndex <= hilbertPkg::coeffIndexWidth'(hilbertPkg::tapCount - 1);
			end
		end
	end

	// The table lookup is a constant ROM read.
	always_comb begin
		coeffOut = hilbertPkg::coeffTable[tapIndex];
		coeffShift = loading;
	end

endmodule

//--- source/hilbertPkg.sv
package hilbertPkg;

	// Input samples are signed two's complement words.
	localparam int dataWidth = 18;

	// Products and sums keep the full width of an 18 by 18 multiply.
	localparam int productWidth = 2 * dataWidth;

	// The Hilbert FIR is odd length, so it has a single center tap.
	localparam int tapCount = 27;

	// The real path is delayed by the index of the center tap.
	localparam int groupDelay = (tapCount - 1) / 2;

	// Enough bits to count down from tapCount - 1 to zero.
	localparam int coeffIndexWidth = 5;

	// Registered stages between a push and the FIR sum output.
	localparam int firStages = 2;

	// The input buffer holds one sample per upstream credit.
	localparam int inCredits = 2;
	localparam int bufferPtrWidth = $clog2(inCredits);
	localparam int bufferCountWidth = $clog2(inCredits + 1);

	// Downstream owns four output slots, and the counter holds up to four.
	localparam int outCredits = 4;
	localparam int creditWidth = 3;

	// Encoding of the control phases.
	localparam int stateWidth = 2;
	localparam logic [stateWidth-1:0] stateIdle = 2'd0;
	localparam logic [stateWidth-1:0] stateLoading = 2'd1;
	localparam logic [stateWidth-1:0] stateStreaming = 2'd2;
	localparam logic [stateWidth-1:0] stateDraining = 2'd3;

	// Q1.17 taps of the ideal Hilbert response 2 / (pi * offset).
	// Index 13 is the center. Even offsets carry no weight.
	// Taps left of the center are negative, taps right of it positive.
	localparam logic signed [dataWidth-1:0] coeffTable [tapCount] = '{
		-18'sd6419, 18'sd0, -18'sd7586, 18'sd0,
		-18'sd9271, 18'sd0, -18'sd11920, 18'sd0,
		-18'sd16689, 18'sd0, -18'sd27814, 18'sd0,
		-18'sd83443, 18'sd0, 18'sd83443, 18'sd0,
		18'sd27814, 18'sd0, 18'sd16689, 18'sd0,
		18'sd11920, 18'sd0, 18'sd9271, 18'sd0,
		18'sd7586, 18'sd0, 18'sd6419
	};

endpackage
